/* logic/dcache_pkg.sv */
package dcache_pkg;

    // ************************************************************************
    // Cache geometry
    // ************************************************************************

    localparam int ADDR_W = 32;
    localparam int WAYS   = 2;
    localparam int SETS   = 16;
    localparam int SET_W  = 4;       // log2(SETS)
    localparam int BANKS  = 4;       // 32-bit words per line
    localparam int BANK_W = 2;
    localparam int TAG_W  = 24;
    localparam int LINE_W = 128;

    // Miss handler states
    localparam logic [1:0] MISS_IDLE    = 2'd0;
    localparam logic [1:0] MISS_WAIT    = 2'd1;   // Refill on the bus
    localparam logic [1:0] MISS_DELIVER = 2'd2;   // Line handed to the cache

    // ************************************************************************
    // Address, seen as one word or as its fields
    // ************************************************************************

    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [TAG_W-1:0]  tag;
            logic [SET_W-1:0]  index;
            logic [BANK_W-1:0] bank;
            logic [1:0]        byte_off;
        } f;
    } dcache_addr_t;

endpackage

/* logic/dcache_way.sv */
`timescale 1ns/100ps

module dcache_way (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [dcache_pkg::SET_W-1:0]  rd_index,
    input  logic                          wr_en,
    input  logic [dcache_pkg::SET_W-1:0]  wr_index,
    input  logic [dcache_pkg::TAG_W-1:0]  wr_tag,
    input  logic [dcache_pkg::LINE_W-1:0] wr_data,
    input  logic                          wr_dirty,
    input  logic                          clr_en,
    input  logic [dcache_pkg::SET_W-1:0]  clr_index,
    output logic                          rd_valid,
    output logic                          rd_dirty,
    output logic [dcache_pkg::TAG_W-1:0]  rd_tag,
    output logic [dcache_pkg::LINE_W-1:0] rd_data
);

    logic [dcache_pkg::SETS-1:0]   valid;
    logic [dcache_pkg::SETS-1:0]   dirty;
    logic [dcache_pkg::TAG_W-1:0]  tags  [dcache_pkg::SETS];
    logic [dcache_pkg::LINE_W-1:0] lines [dcache_pkg::SETS];

    // Clear sweep wins over a fill
    always_ff @(posedge clk) begin
        if (clr_en) begin
            valid[clr_index] <= 1'b0;
            dirty[clr_index] <= 1'b0;
        end else if (wr_en && !rst) begin
            valid[wr_index] <= 1'b1;
            dirty[wr_index] <= wr_dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tags[wr_index]  <= wr_tag;
            lines[wr_index] <= wr_data;
        end
    end

    assign rd_valid = valid[rd_index];   // Asynchronous read
    assign rd_dirty = dirty[rd_index];
    assign rd_tag   = tags[rd_index];
    assign rd_data  = lines[rd_index];

endmodule

/* logic/dcache_miss.sv */
`timescale 1ns/100ps

module dcache_miss (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          miss_start,
    input  dcache_pkg::dcache_addr_t      miss_addr,
    input  logic                          miss_way,
    input  logic                          refill_ack,
    input  logic [dcache_pkg::LINE_W-1:0] refill_rdata,
    output logic                          refill_req,
    output dcache_pkg::dcache_addr_t      refill_addr,
    output logic                          refill_valid,
    output logic [dcache_pkg::LINE_W-1:0] refill_data,
    output logic                          refill_way,
    output logic                          miss_busy
);

    logic [1:0] state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= dcache_pkg::MISS_IDLE;
        end else begin
            case (state)
                dcache_pkg::MISS_IDLE: begin
                    if (miss_start) begin
                        state <= dcache_pkg::MISS_WAIT;
                    end
                end
                dcache_pkg::MISS_WAIT: begin
                    if (refill_ack) begin
                        state <= dcache_pkg::MISS_DELIVER;
                    end
                end
                default: begin
                    state <= dcache_pkg::MISS_IDLE;   // Delivery lasts one cycle
                end
            endcase
        end
    end

    // Line-aligned miss address and victim way
    always_ff @(posedge clk) begin
        if (state == dcache_pkg::MISS_IDLE && miss_start) begin
            refill_addr.raw <= {miss_addr.f.tag, miss_addr.f.index,
                                {(dcache_pkg::BANK_W + 2){1'b0}}};
            refill_way      <= miss_way;
        end
    end

    always_ff @(posedge clk) begin
        if (state == dcache_pkg::MISS_WAIT && refill_ack) begin
            refill_data <= refill_rdata;
        end
    end

    assign refill_req   = (state == dcache_pkg::MISS_WAIT);
    assign refill_valid = (state == dcache_pkg::MISS_DELIVER);
    assign miss_busy    = (state != dcache_pkg::MISS_IDLE);

endmodule

/* logic/dcache_writeback.sv */
`timescale 1ns/100ps

module dcache_writeback (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wb_start,
    input  dcache_pkg::dcache_addr_t      wb_addr,
    input  logic [dcache_pkg::LINE_W-1:0] wb_data,
    input  logic                          wb_ack,
    output logic                          wb_req,
    output logic [dcache_pkg::ADDR_W-1:0] wb_buf_addr,
    output logic [dcache_pkg::LINE_W-1:0] wb_buf_data
);

    // Request held until the bus acks it
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_req <= 1'b0;
        end else if (wb_start) begin
            wb_req <= 1'b1;
        end else if (wb_ack) begin
            wb_req <= 1'b0;
        end
    end

    // Victim line buffer
    always_ff @(posedge clk) begin
        if (wb_start) begin
            wb_buf_addr <= {wb_addr.f.tag, wb_addr.f.index, {(dcache_pkg::BANK_W + 2){1'b0}}};
            wb_buf_data <= wb_data;
        end
    end

endmodule

/* logic/mem_arbiter.sv */
`timescale 1ns/100ps

module mem_arbiter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wb_req,
    input  logic [dcache_pkg::ADDR_W-1:0] wb_addr,
    input  logic [dcache_pkg::LINE_W-1:0] wb_data,
    input  logic                          refill_req,
    input  logic [dcache_pkg::ADDR_W-1:0] refill_addr,
    input  logic                          mem_ack,
    input  logic [dcache_pkg::LINE_W-1:0] mem_rdata,
    output logic                          wb_ack,
    output logic                          refill_ack,
    output logic [dcache_pkg::LINE_W-1:0] refill_rdata,
    output logic                          mem_req,
    output logic                          mem_we,
    output logic [dcache_pkg::ADDR_W-1:0] mem_addr,
    output logic [dcache_pkg::LINE_W-1:0] mem_wdata
);

    logic gnt_wb;
    logic gnt_rf;

    always_ff @(posedge clk) begin
        if (rst || mem_ack) begin
            gnt_wb <= 1'b0;
            gnt_rf <= 1'b0;
        end else if (!gnt_wb && !gnt_rf) begin
            gnt_wb <= wb_req;                  // Writeback first
            gnt_rf <= refill_req && !wb_req;
        end
    end

    assign mem_req   = gnt_wb || gnt_rf;
    assign mem_we    = gnt_wb;
    assign mem_addr  = gnt_wb ? wb_addr : refill_addr;
    assign mem_wdata = wb_data;

    assign wb_ack       = mem_ack && gnt_wb;
    assign refill_ack   = mem_ack && gnt_rf;
    assign refill_rdata = mem_rdata;

endmodule

/* logic/dcache.sv */
`timescale 1ns/100ps

module dcache (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          load_req,
    input  logic [dcache_pkg::ADDR_W-1:0] load_addr,
    input  logic                          store_req,
    input  logic [dcache_pkg::ADDR_W-1:0] store_addr,
    input  logic [31:0]                   store_data,
    input  logic [3:0]                    store_mask,
    input  logic                          mem_ack,
    input  logic [dcache_pkg::LINE_W-1:0] mem_rdata,
    output logic                          load_ready,
    output logic                          load_valid,
    output logic                          load_hit,
    output logic [31:0]                   load_data,
    output logic                          store_ready,
    output logic                          store_done,
    output logic                          mem_req,
    output logic                          mem_we,
    output logic [dcache_pkg::ADDR_W-1:0] mem_addr,
    output logic [dcache_pkg::LINE_W-1:0] mem_wdata
);

    logic                                   init_busy;
    logic [dcache_pkg::SET_W-1:0]           init_cnt;
    logic [dcache_pkg::SETS-1:0]            lru;        // Way to evict next
    logic                                   ready;
    logic                                   accept;
    logic                                   s1_valid;
    logic                                   s1_store;
    logic                                   s1_missed;
    dcache_pkg::dcache_addr_t               s1_addr;
    logic [31:0]                            s1_data;
    logic [3:0]                             s1_mask;

    logic [dcache_pkg::WAYS-1:0]            way_valid;
    logic [dcache_pkg::WAYS-1:0]            way_dirty;
    logic [dcache_pkg::WAYS-1:0]            way_hit;
    logic [dcache_pkg::WAYS-1:0]            way_wr_en;
    logic [dcache_pkg::TAG_W-1:0]           way_tag  [dcache_pkg::WAYS];
    logic [dcache_pkg::LINE_W-1:0]          way_data [dcache_pkg::WAYS];
    logic                                   hit;
    logic                                   hit_way;
    logic                                   victim;
    logic [dcache_pkg::BANKS-1:0][31:0]     hit_line;
    logic [dcache_pkg::BANKS-1:0][3:0][7:0] merged;
    logic [dcache_pkg::SET_W-1:0]           wr_index;
    logic [dcache_pkg::TAG_W-1:0]           wr_tag;
    logic [dcache_pkg::LINE_W-1:0]          wr_data;
    logic                                   wr_dirty;

    logic                                   miss_start;
    logic                                   miss_busy;
    logic                                   refill_req;
    logic                                   refill_ack;
    logic                                   refill_valid;
    logic                                   refill_way;
    dcache_pkg::dcache_addr_t               refill_addr;
    logic [dcache_pkg::LINE_W-1:0]          refill_data;
    logic [dcache_pkg::LINE_W-1:0]          refill_rdata;
    logic                                   wb_start;
    logic                                   wb_req;
    logic                                   wb_ack;
    dcache_pkg::dcache_addr_t               wb_addr;
    logic [dcache_pkg::ADDR_W-1:0]          wb_buf_addr;
    logic [dcache_pkg::LINE_W-1:0]          wb_buf_data;

    // ************************************************************************
    // Reset sweep over the valid bits
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            init_busy <= 1'b1;
            init_cnt  <= '0;
        end else if (init_busy) begin
            init_cnt <= init_cnt + 1'b1;
            if (init_cnt == dcache_pkg::SET_W'(dcache_pkg::SETS - 1)) begin
                init_busy <= 1'b0;
            end
        end
    end

    // ************************************************************************
    // Lookup stage
    // ************************************************************************

    assign ready  = !init_busy && !miss_busy && !(s1_valid && !hit);
    assign accept = ready && (load_req || store_req);

    // A missing request stays here until its line arrives
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            s1_missed <= 1'b0;
        end else begin
            s1_valid <= accept || (s1_valid && !hit);
            if (accept) begin
                s1_missed <= 1'b0;
            end else if (miss_start) begin
                s1_missed <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_store    <= store_req;   // Store wins a tie
            s1_addr.raw <= store_req ? store_addr : load_addr;
            s1_data     <= store_data;
            s1_mask     <= store_mask;
        end
    end

    for (genvar w = 0; w < dcache_pkg::WAYS; w++) begin : g_way
        dcache_way way_inst (
            .clk       (clk),
            .rst       (rst),
            .rd_index  (s1_addr.f.index),
            .wr_en     (way_wr_en[w]),
            .wr_index  (wr_index),
            .wr_tag    (wr_tag),
            .wr_data   (wr_data),
            .wr_dirty  (wr_dirty),
            .clr_en    (init_busy),
            .clr_index (init_cnt),
            .rd_valid  (way_valid[w]),
            .rd_dirty  (way_dirty[w]),
            .rd_tag    (way_tag[w]),
            .rd_data   (way_data[w])
        );

        assign way_hit[w] = way_valid[w] && (way_tag[w] == s1_addr.f.tag);
    end

    assign hit      = |way_hit;
    assign hit_way  = way_hit[1];
    assign hit_line = way_data[hit_way];
    assign victim   = lru[s1_addr.f.index];

    assign load_ready  = ready;
    assign store_ready = ready;
    assign load_valid  = s1_valid && !s1_store && hit;
    assign load_hit    = !s1_missed;
    assign load_data   = hit_line[s1_addr.f.bank];
    assign store_done  = s1_valid && s1_store && hit;

    // ************************************************************************
    // Store merge, way writes and replacement
    // ************************************************************************

    always_comb begin
        merged = hit_line;
        for (int b = 0; b < 4; b++) begin
            if (s1_mask[b]) begin
                merged[s1_addr.f.bank][b] = s1_data[b*8 +: 8];
            end
        end
    end

    // Refill and store hit never meet in one cycle
    always_comb begin
        way_wr_en = '0;
        if (refill_valid) begin
            way_wr_en[refill_way] = 1'b1;
            wr_index = refill_addr.f.index;
            wr_tag   = refill_addr.f.tag;
            wr_data  = refill_data;
            wr_dirty = 1'b0;
        end else begin
            way_wr_en[hit_way] = store_done;
            wr_index = s1_addr.f.index;
            wr_tag   = s1_addr.f.tag;
            wr_data  = merged;
            wr_dirty = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lru <= '0;
        end else if (refill_valid) begin
            lru[refill_addr.f.index] <= !refill_way;
        end else if (s1_valid && hit) begin
            lru[s1_addr.f.index] <= !hit_way;
        end
    end

    // ************************************************************************
    // Miss, writeback and memory bus
    // ************************************************************************

    assign miss_start  = s1_valid && !hit && !miss_busy;
    assign wb_start    = miss_start && way_valid[victim] && way_dirty[victim];
    assign wb_addr.raw = {way_tag[victim], s1_addr.f.index, {(dcache_pkg::BANK_W + 2){1'b0}}};

    dcache_miss miss_inst (
        .clk          (clk),
        .rst          (rst),
        .miss_start   (miss_start),
        .miss_addr    (s1_addr),
        .miss_way     (victim),
        .refill_ack   (refill_ack),
        .refill_rdata (refill_rdata),
        .refill_req   (refill_req),
        .refill_addr  (refill_addr),
        .refill_valid (refill_valid),
        .refill_data  (refill_data),
        .refill_way   (refill_way),
        .miss_busy    (miss_busy)
    );

    dcache_writeback wb_inst (
        .clk         (clk),
        .rst         (rst),
        .wb_start    (wb_start),
        .wb_addr     (wb_addr),
        .wb_data     (way_data[victim]),
        .wb_ack      (wb_ack),
        .wb_req      (wb_req),
        .wb_buf_addr (wb_buf_addr),
        .wb_buf_data (wb_buf_data)
    );

    mem_arbiter arb_inst (
        .clk          (clk),
        .rst          (rst),
        .wb_req       (wb_req),
        .wb_addr      (wb_buf_addr),
        .wb_data      (wb_buf_data),
        .refill_req   (refill_req),
        .refill_addr  (refill_addr.raw),
        .mem_ack      (mem_ack),
        .mem_rdata    (mem_rdata),
        .wb_ack       (wb_ack),
        .refill_ack   (refill_ack),
        .refill_rdata (refill_rdata),
        .mem_req      (mem_req),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata)
    );

endmodule

/* bench/mem_model.sv */
`timescale 1ns/100ps

module mem_model (
    input  logic         clk,
    input  logic         rst,
    input  logic         mem_req,
    input  logic         mem_we,
    input  logic [31:0]  mem_addr,
    input  logic [127:0] mem_wdata,
    output logic         mem_ack,
    output logic [127:0] mem_rdata
);

    logic [127:0] mem [1024];   // Lines of the low 16 KB
    logic         busy;
    logic [2:0]   delay;
    int           seed = 33;

    function automatic logic [127:0] fill_line(int line);
        logic [127:0] l;
        for (int w = 0; w < 4; w++) begin
            l[w*32 +: 32] = 32'((line << 4) + (w << 2)) ^ 32'h3C5A_0F96;   // Address XOR constant
        end
        return l;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            mem_ack   <= 1'b0;
            mem_rdata <= '0;
            busy      <= 1'b0;
            delay     <= 3'd0;
            for (int i = 0; i < 1024; i++) begin
                mem[i] <= fill_line(i);
            end
        end else begin
            mem_ack <= 1'b0;
            if (mem_req && !busy && !mem_ack) begin
                busy  <= 1'b1;
                delay <= 3'($unsigned($random(seed)) % 32'd6);   // Random latency
            end else if (busy && delay != 3'd0) begin
                delay <= delay - 3'd1;
            end else if (busy) begin
                busy    <= 1'b0;
                mem_ack <= 1'b1;
                if (mem_we) begin
                    mem[mem_addr[13:4]] <= mem_wdata;
                end else begin
                    mem_rdata <= mem[mem_addr[13:4]];
                end
            end
        end
    end

endmodule

/* bench/dcache_tb.sv */
`timescale 1ns/100ps

module dcache_tb;

    logic         clk;
    logic         rst;
    logic         load_req;
    logic [31:0]  load_addr;
    logic         store_req;
    logic [31:0]  store_addr;
    logic [31:0]  store_data;
    logic [3:0]   store_mask;
    logic         mem_ack;
    logic [127:0] mem_rdata;
    logic         load_ready;
    logic         load_valid;
    logic         load_hit;
    logic [31:0]  load_data;
    logic         store_ready;
    logic         store_done;
    logic         mem_req;
    logic         mem_we;
    logic [31:0]  mem_addr;
    logic [127:0] mem_wdata;

    int           seed;
    int           wb_count;         // Line writes acked by memory
    int           max_wait = 100;
    logic [31:0]  mirror [4096];    // Expected words of the low 16 KB

    dcache dcache_inst (
        .clk         (clk),
        .rst         (rst),
        .load_req    (load_req),
        .load_addr   (load_addr),
        .store_req   (store_req),
        .store_addr  (store_addr),
        .store_data  (store_data),
        .store_mask  (store_mask),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata),
        .load_ready  (load_ready),
        .load_valid  (load_valid),
        .load_hit    (load_hit),
        .load_data   (load_data),
        .store_ready (store_ready),
        .store_done  (store_done),
        .mem_req     (mem_req),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata)
    );

    mem_model mem_model_inst (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    always #50 clk = ~clk;

    always @(negedge clk) begin
        if (mem_ack && mem_we) begin
            wb_count = wb_count + 1;
        end
    end

    // ************************************************************************
    // Helpers
    // ************************************************************************

    function automatic logic [31:0] make_addr(logic [23:0] tag, logic [3:0] set,
                                              logic [1:0] bank);
        dcache_pkg::dcache_addr_t a;
        a.raw     = '0;
        a.f.tag   = tag;
        a.f.index = set;
        a.f.bank  = bank;
        return a.raw;
    endfunction

    task automatic abort_run(input string what);
        $display("Timeout, %s", what);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error in %s, expected %h, actual %h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk);
        while (!load_ready) begin
            n++;
            if (n > max_wait) begin
                abort_run("load_ready never went high");
            end
            @(negedge clk);
        end
    endtask

    task automatic run_load(input logic [31:0] addr, output logic [31:0] data,
                            output logic hit, output int lat);
        wait_ready();
        @(posedge clk);
        load_req  <= 1'b1;
        load_addr <= addr;
        @(posedge clk);
        load_req <= 1'b0;
        lat = 1;
        @(negedge clk);
        while (!load_valid) begin
            lat++;
            if (lat > max_wait) begin
                abort_run("load_valid never came");
            end
            @(negedge clk);
        end
        data = load_data;
        hit  = load_hit;
    endtask

    task automatic run_store(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] mask, output int lat);
        wait_ready();
        @(posedge clk);
        store_req  <= 1'b1;
        store_addr <= addr;
        store_data <= data;
        store_mask <= mask;
        @(posedge clk);
        store_req <= 1'b0;
        lat = 1;
        @(negedge clk);
        while (!store_done) begin
            lat++;
            if (lat > max_wait) begin
                abort_run("store_done never came");
            end
            @(negedge clk);
        end
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                mirror[addr[13:2]][b*8 +: 8] = data[b*8 +: 8];
            end
        end
    endtask

    task automatic load_and_check(input string name, input logic [31:0] addr,
                                  output logic hit, output int lat);
        logic [31:0] data;
        run_load(addr, data, hit, lat);
        check(name, mirror[addr[13:2]], data);
    endtask

    task automatic check_mem_line(input string name, input logic [31:0] addr);
        logic [127:0] line;
        line = mem_model_inst.mem[addr[13:4]];
        for (int b = 0; b < 4; b++) begin
            check(name, mirror[{addr[13:4], 2'(b)}], line[b*32 +: 32]);
        end
    endtask

    // ************************************************************************
    // Directed tests
    // ************************************************************************

    task automatic test_reset();
        @(negedge clk);
        check("reset load_valid", 32'd0, 32'(load_valid));
        check("reset store_done", 32'd0, 32'(store_done));
        check("reset mem_req", 32'd0, 32'(mem_req));
        check("reset ready during sweep", 32'd0, 32'(load_ready));
        wait_ready();
        check("reset store_ready", 32'd1, 32'(store_ready));
    endtask

    task automatic test_load_miss_hit();
        logic hit;
        int   lat;
        load_and_check("load miss data", make_addr(24'd2, 4'd1, 2'd0), hit, lat);
        check("load miss flag", 32'd0, 32'(hit));
        load_and_check("load hit data", make_addr(24'd2, 4'd1, 2'd3), hit, lat);
        check("load hit flag", 32'd1, 32'(hit));
        check("load hit latency", 32'd1, 32'(lat));
    endtask

    task automatic test_store_merge();
        logic [31:0] x;
        logic [31:0] y;
        logic        hit;
        int          lat;
        x = make_addr(24'd3, 4'd2, 2'd1);
        y = make_addr(24'd4, 4'd2, 2'd2);
        load_and_check("store hit line fetch", x, hit, lat);
        run_store(x, 32'hA5C3_7E19, 4'b0101, lat);
        check("store hit latency", 32'd1, 32'(lat));
        load_and_check("store hit merged", x, hit, lat);
        run_store(y, 32'h1B2D_3F40, 4'b1010, lat);   // Store miss
        load_and_check("store miss merged", y, hit, lat);
        check("store miss line present", 32'd1, 32'(hit));
    endtask

    task automatic test_dirty_eviction();
        logic [31:0] a;
        logic [31:0] b;
        logic        hit;
        int          lat;
        int          wb0;
        a = make_addr(24'd1, 4'd3, 2'd0);
        b = make_addr(24'd2, 4'd3, 2'd2);
        run_store(a, 32'hDEAD_BEEF, 4'b1111, lat);
        run_store(b, 32'h0BAD_F00D, 4'b0011, lat);
        wb0 = wb_count;
        load_and_check("evict A load C", make_addr(24'd3, 4'd3, 2'd1), hit, lat);
        check("evict A write count", 32'(wb0 + 1), 32'(wb_count));
        check_mem_line("evict A memory", a);
        load_and_check("evict B load D", make_addr(24'd4, 4'd3, 2'd1), hit, lat);
        check("evict B write count", 32'(wb0 + 2), 32'(wb_count));
        check_mem_line("evict B memory", b);
    endtask

    task automatic test_lru_order();
        logic hit;
        int   lat;
        load_and_check("lru load A", make_addr(24'd1, 4'd4, 2'd0), hit, lat);
        load_and_check("lru load B", make_addr(24'd2, 4'd4, 2'd0), hit, lat);
        load_and_check("lru reload A", make_addr(24'd1, 4'd4, 2'd1), hit, lat);
        check("lru reload A hit", 32'd1, 32'(hit));
        load_and_check("lru load C", make_addr(24'd3, 4'd4, 2'd0), hit, lat);
        check("lru load C miss", 32'd0, 32'(hit));
        load_and_check("lru A kept", make_addr(24'd1, 4'd4, 2'd2), hit, lat);
        check("lru A kept hit", 32'd1, 32'(hit));
        load_and_check("lru B evicted", make_addr(24'd2, 4'd4, 2'd2), hit, lat);
        check("lru B evicted miss", 32'd0, 32'(hit));
    endtask

    task automatic test_random_mix();
        logic [31:0] u;
        logic [31:0] d;
        logic [31:0] a;
        logic        hit;
        int          lat;
        for (int i = 0; i < 200; i++) begin
            u = $random(seed);
            d = $random(seed);
            a = make_addr(24'(u % 32'd6 + 32'd1), 4'((u >> 4) % 32'd3 + 32'd5), 2'(u >> 8));
            if (u[12]) begin
                run_store(a, d, 4'(u >> 16), lat);
            end else begin
                load_and_check("random load", a, hit, lat);
            end
        end
        // Two new tags per set push both ways out
        for (int s = 5; s < 8; s++) begin
            load_and_check("flush load", make_addr(24'd20, 4'(s), 2'd0), hit, lat);
            load_and_check("flush load", make_addr(24'd21, 4'(s), 2'd0), hit, lat);
        end
        for (int t = 1; t <= 6; t++) begin
            for (int s = 5; s < 8; s++) begin
                check_mem_line("random flushed line", make_addr(24'(t), 4'(s), 2'd0));
            end
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        load_req   = 1'b0;
        load_addr  = '0;
        store_req  = 1'b0;
        store_addr = '0;
        store_data = '0;
        store_mask = '0;
        seed       = 33;
        wb_count   = 0;
        for (int k = 0; k < 4096; k++) begin
            mirror[k] = 32'(k << 2) ^ 32'h3C5A_0F96;   // Memory fill pattern
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_load_miss_hit();
        test_store_merge();
        test_dirty_eviction();
        test_lru_order();
        test_random_mix();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* dcache.f */
logic/dcache_pkg.sv
logic/dcache_way.sv
logic/dcache_miss.sv
logic/dcache_writeback.sv
logic/mem_arbiter.sv
logic/dcache.sv
bench/mem_model.sv
bench/dcache_tb.sv

/* run.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --top-module dcache_tb -f dcache.f -o dcache_sim \
    && ./obj_dir/dcache_sim 2>&1 | tee sim.log \
    || echo "Build or simulation ended with an error"
grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "Simulation failed"; exit 1; } \
    || { grep -q '\*\*\* PASSED \*\*\*' sim.log && echo "Simulation passed"; }
